// File: Makefile
SRCS := $(shell cat fft8.f)

.PHONY: run clean

run: obj_dir/Vtb_fft
	./obj_dir/Vtb_fft > sim.log 2>&1
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log

obj_dir/Vtb_fft: fft8.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fft -f fft8.f

clean:
	rm -rf obj_dir sim.log

// File: common/fft_pkg.sv
`default_nettype none

package fft_pkg;

    // Transform size
    localparam int fft_n    = 8;
    localparam int fft_half = fft_n / 2;

    // Fixed-point formats
    localparam int sample_w     = 16;
    localparam int twiddle_w    = 16;
    localparam int twiddle_frac = 14;

    typedef logic signed [sample_w-1:0] sample_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } complex_t;

    // Position of a pair within a frame
    typedef logic [$clog2(fft_half)-1:0] pair_idx_t;

    typedef logic [$clog2(fft_n)-1:0] bin_idx_t;

    typedef complex_t [fft_n-1:0] spectrum_t;

    // Q2.14 twiddle factor
    typedef struct packed {
        logic signed [twiddle_w-1:0] re;
        logic signed [twiddle_w-1:0] im;
    } twiddle_t;

    // W8^k for k = 0..3
    localparam twiddle_t twiddle_rom [fft_half] = '{
        '{re: 16'sd16384,  im: 16'sd0},
        '{re: 16'sd11585,  im: -16'sd11585},
        '{re: 16'sd0,      im: -16'sd16384},
        '{re: -16'sd11585, im: -16'sd11585}
    };

    // Front end pairing FSM
    typedef enum logic {
        load_low,
        emit_pairs
    } pair_state_t;

endpackage

`default_nettype wire

// File: fft/butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module butterfly #(
    parameter int STAGE = 0
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    enable,
    input  wire fft_pkg::complex_t a,
    input  wire fft_pkg::complex_t b,
    output fft_pkg::complex_t      x,
    output fft_pkg::complex_t      y,
    output logic                   out_valid
);

    fft_pkg::pair_idx_t pair_cnt;
    fft_pkg::pair_idx_t tw_idx;
    fft_pkg::twiddle_t  tw;

    // One guard bit for sum and difference
    logic signed [fft_pkg::sample_w:0] sum_re;
    logic signed [fft_pkg::sample_w:0] sum_im;
    logic signed [fft_pkg::sample_w:0] dif_re;
    logic signed [fft_pkg::sample_w:0] dif_im;

    fft_pkg::sample_t d_re;
    fft_pkg::sample_t d_im;

    logic signed [fft_pkg::sample_w+fft_pkg::twiddle_w:0] prod_re;
    logic signed [fft_pkg::sample_w+fft_pkg::twiddle_w:0] prod_im;

    // Stride of the twiddle doubles each stage
    assign tw_idx = pair_cnt << STAGE;
    assign tw     = fft_pkg::twiddle_rom[tw_idx];

    always_comb begin
        sum_re = a.re + b.re;
        sum_im = a.im + b.im;
        dif_re = a.re - b.re;
        dif_im = a.im - b.im;

        // Halved difference feeds the multiplier
        d_re = dif_re[fft_pkg::sample_w:1];
        d_im = dif_im[fft_pkg::sample_w:1];

        prod_re = d_re * tw.re - d_im * tw.im;
        prod_im = d_re * tw.im + d_im * tw.re;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pair_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= enable;
            if (enable) begin
                pair_cnt <= pair_cnt + 1'b1;
            end else begin
                pair_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            x.re <= sum_re[fft_pkg::sample_w:1];
            x.im <= sum_im[fft_pkg::sample_w:1];
            // Truncate away the Q2.14 fraction
            y.re <= prod_re[fft_pkg::twiddle_frac +: fft_pkg::sample_w];
            y.im <= prod_im[fft_pkg::twiddle_frac +: fft_pkg::sample_w];
        end
    end

endmodule

`default_nettype wire

// File: fft/delay_commutator.sv
`timescale 1ns/1ps
`default_nettype none

module delay_commutator #(
    parameter int DELAY = 2
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    enable,
    input  wire fft_pkg::complex_t x0,
    input  wire fft_pkg::complex_t x1,
    output fft_pkg::complex_t      y0,
    output fft_pkg::complex_t      y1,
    output logic                   out_valid
);

    fft_pkg::complex_t  lower_dly [DELAY];
    fft_pkg::complex_t  upper_dly [DELAY];
    fft_pkg::complex_t  lower_tap;
    fft_pkg::complex_t  sw_upper;
    fft_pkg::complex_t  sw_lower;
    fft_pkg::pair_idx_t pair_cnt;
    logic [DELAY-1:0]   vld_sr;
    logic               swap;

    // Toggles every DELAY pairs and rests straight-through when idle
    assign swap = pair_cnt[DELAY-1];

    assign lower_tap = lower_dly[DELAY-1];
    assign sw_upper  = swap ? lower_tap : x0;
    assign sw_lower  = swap ? x0 : lower_tap;

    assign y0        = upper_dly[DELAY-1];
    assign y1        = sw_lower;
    assign out_valid = vld_sr[DELAY-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pair_cnt <= '0;
            vld_sr   <= '0;
        end else begin
            vld_sr[0] <= enable;
            for (int i = 1; i < DELAY; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
            if (enable) begin
                pair_cnt <= pair_cnt + 1'b1;
            end else begin
                pair_cnt <= '0;
            end
        end
    end

    // Both lines shift every cycle so the tail of a frame drains
    always_ff @(posedge clk) begin
        lower_dly[0] <= x1;
        upper_dly[0] <= sw_upper;
        for (int i = 1; i < DELAY; i++) begin
            lower_dly[i] <= lower_dly[i-1];
            upper_dly[i] <= upper_dly[i-1];
        end
    end

endmodule

`default_nettype wire

// File: fft/fft_8_rad2.sv
`timescale 1ns/1ps
`default_nettype none

module fft_8_rad2 (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    enable,
    input  wire fft_pkg::complex_t data_0,
    input  wire fft_pkg::complex_t data_1,
    output fft_pkg::spectrum_t     fft_out,
    output logic                   out_valid
);

    fft_pkg::complex_t  bf0_x;
    fft_pkg::complex_t  bf0_y;
    logic               bf0_valid;
    fft_pkg::complex_t  dc2_y0;
    fft_pkg::complex_t  dc2_y1;
    logic               dc2_valid;
    fft_pkg::complex_t  bf1_x;
    fft_pkg::complex_t  bf1_y;
    logic               bf1_valid;
    fft_pkg::complex_t  dc1_y0;
    fft_pkg::complex_t  dc1_y1;
    logic               dc1_valid;
    fft_pkg::complex_t  bf2_x;
    fft_pkg::complex_t  bf2_y;
    logic               bf2_valid;

    fft_pkg::spectrum_t output_buffer;
    fft_pkg::pair_idx_t w_ptr;
    logic               buffer_ready;

    butterfly #(.STAGE(0)) bf_0 (
        .clk(clk), .arst_n(arst_n), .enable(enable),
        .a(data_0), .b(data_1),
        .x(bf0_x), .y(bf0_y), .out_valid(bf0_valid)
    );

    delay_commutator #(.DELAY(2)) dc_2 (
        .clk(clk), .arst_n(arst_n), .enable(bf0_valid),
        .x0(bf0_x), .x1(bf0_y),
        .y0(dc2_y0), .y1(dc2_y1), .out_valid(dc2_valid)
    );

    butterfly #(.STAGE(1)) bf_1 (
        .clk(clk), .arst_n(arst_n), .enable(dc2_valid),
        .a(dc2_y0), .b(dc2_y1),
        .x(bf1_x), .y(bf1_y), .out_valid(bf1_valid)
    );

    delay_commutator #(.DELAY(1)) dc_1 (
        .clk(clk), .arst_n(arst_n), .enable(bf1_valid),
        .x0(bf1_x), .x1(bf1_y),
        .y0(dc1_y0), .y1(dc1_y1), .out_valid(dc1_valid)
    );

    butterfly #(.STAGE(2)) bf_2 (
        .clk(clk), .arst_n(arst_n), .enable(dc1_valid),
        .a(dc1_y0), .b(dc1_y1),
        .x(bf2_x), .y(bf2_y), .out_valid(bf2_valid)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_ptr        <= '0;
            buffer_ready <= 1'b0;
        end else if (bf2_valid) begin
            w_ptr        <= w_ptr + 1'b1;
            buffer_ready <= (w_ptr == '1);
        end else begin
            w_ptr        <= '0;
            buffer_ready <= 1'b0;
        end
    end

    // Final pair holds adjacent bit-reversed bins
    always_ff @(posedge clk) begin
        if (bf2_valid) begin
            output_buffer[{w_ptr, 1'b0}] <= bf2_x;
            output_buffer[{w_ptr, 1'b1}] <= bf2_y;
        end
    end

    input_reorder reorder (
        .clk(clk),
        .arst_n(arst_n),
        .enable(buffer_ready),
        .input_array(output_buffer),
        .output_array(fft_out),
        .out_valid(out_valid)
    );

endmodule

`default_nettype wire

// File: fft8.f
common/fft_pkg.sv
fft/butterfly.sv
fft/delay_commutator.sv
verilog/input_reorder.sv
fft/fft_8_rad2.sv
verilog/input_pairing.sv
verilog/fft_top.sv
sim/tb_clock.sv
sim/tb_fft.sv

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_fft.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fft;

    // W8^k in Q2.14
    localparam int tw_re [4] = '{16384, 11585, 0, -11585};
    localparam int tw_im [4] = '{0, -11585, -16384, -11585};

    logic               clk;
    logic               arst_n;
    fft_pkg::complex_t  sample_in;
    logic               sample_valid;
    fft_pkg::spectrum_t spectrum;
    logic               spectrum_valid;

    fft_pkg::spectrum_t exp_q [$];
    string              name_q [$];
    int                 due_q [$];

    int          cyc = 0;
    logic [2:0]  frame_pos;
    logic [31:0] rng;
    int          mismatch_errs = 0;
    int          timing_errs = 0;
    int          other_errs = 0;

    tb_clock clock_gen (
        .clk(clk)
    );

    fft_top uut (
        .clk(clk),
        .arst_n(arst_n),
        .sample_in(sample_in),
        .sample_valid(sample_valid),
        .spectrum(spectrum),
        .spectrum_valid(spectrum_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int next_sample();
        return int'(next_rand() % 32'd16383) - 8191;
    endfunction

    function automatic int wrap16(input int v);
        logic signed [15:0] t;
        t = v[15:0];
        return t;
    endfunction

    function automatic int rev3(input int k);
        return {k[0], k[1], k[2]};
    endfunction

    // Halved sum on top and halved difference times W8^k below
    function automatic void radix2_step(
        input int ar, input int ai, input int br, input int bi, input int k,
        output int xr, output int xi, output int yr, output int yi
    );
        int dr;
        int di;
        xr = wrap16((ar + br) >>> 1);
        xi = wrap16((ai + bi) >>> 1);
        dr = wrap16((ar - br) >>> 1);
        di = wrap16((ai - bi) >>> 1);
        yr = wrap16((dr * tw_re[k] - di * tw_im[k]) >>> 14);
        yi = wrap16((dr * tw_im[k] + di * tw_re[k]) >>> 14);
    endfunction

    // In-place DIF leaves results in bit-reversed slots
    function automatic fft_pkg::spectrum_t fft_model(input int in_re [8], input int in_im [8]);
        int ar [8];
        int ai [8];
        int span;
        int lo;
        int hi;
        int xr;
        int xi;
        int yr;
        int yi;
        fft_pkg::spectrum_t res;
        ar = in_re;
        ai = in_im;
        for (int s = 0; s < 3; s++) begin
            span = 4 >> s;
            for (int base = 0; base < 8; base += 2 * span) begin
                for (int m = 0; m < span; m++) begin
                    lo = base + m;
                    hi = lo + span;
                    radix2_step(ar[lo], ai[lo], ar[hi], ai[hi], (m << s) % 4, xr, xi, yr, yi);
                    ar[lo] = xr;
                    ai[lo] = xi;
                    ar[hi] = yr;
                    ai[hi] = yi;
                end
            end
        end
        for (int k = 0; k < 8; k++) begin
            res[k].re = fft_pkg::sample_t'(ar[rev3(k)]);
            res[k].im = fft_pkg::sample_t'(ai[rev3(k)]);
        end
        return res;
    endfunction

    task automatic check_frame();
        fft_pkg::spectrum_t exp_spec;
        string name;
        int due;
        if (exp_q.size() == 0 || due_q.size() == 0) begin
            other_errs++;
            $display("spectrum_valid pulsed with no frame outstanding at cycle %0d", cyc);
        end else begin
            exp_spec = exp_q.pop_front();
            name = name_q.pop_front();
            due = due_q.pop_front();
            assert (cyc == due) else begin
                timing_errs++;
                $display("Mismatch %s latency: expected cycle %0d actual cycle %0d",
                         name, due, cyc);
            end
            for (int k = 0; k < 8; k++) begin
                assert (spectrum[k] == exp_spec[k]) else begin
                    mismatch_errs++;
                    $display("Mismatch %s bin %0d: expected (%0d,%0d) actual (%0d,%0d)",
                             name, k, exp_spec[k].re, exp_spec[k].im,
                             spectrum[k].re, spectrum[k].im);
                end
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            sample_valid <= 1'b0;
            sample_in    <= '0;
        end
    endtask

    task automatic send_frame(input string name, input int re [8], input int im [8],
                              input int gap);
        exp_q.push_back(fft_model(re, im));
        name_q.push_back(name);
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            sample_valid <= 1'b1;
            sample_in.re <= fft_pkg::sample_t'(re[n]);
            sample_in.im <= fft_pkg::sample_t'(im[n]);
        end
        idle_cycles(gap);
    endtask

    task automatic wait_drain(input string name);
        int n;
        n = 0;
        idle_cycles(1);
        while (exp_q.size() != 0 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("Timeout: %0d frames of %s never came out", exp_q.size(), name);
            exp_q.delete();
            name_q.delete();
            due_q.delete();
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(negedge clk) begin
        if (!arst_n) begin
            frame_pos = '0;
        end else begin
            if (sample_valid) begin
                // Eighth sample is taken on the next rising edge
                if (frame_pos == 3'd7) begin
                    due_q.push_back(cyc + 9);
                end
                frame_pos = frame_pos + 3'd1;
            end
            if (spectrum_valid) begin
                check_frame();
            end
        end
    end

    pulse_width: assert property (
        @(posedge clk) disable iff (!arst_n) spectrum_valid |=> !spectrum_valid
    ) else begin
        timing_errs++;
        $display("spectrum_valid stayed high for more than one cycle at cycle %0d", cyc);
    end

    initial begin
        int re [8];
        int im [8];
        int gap;
        arst_n       = 1'b0;
        sample_valid = 1'b0;
        sample_in    = '0;
        rng          = 32'h273a;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // Nothing may come out of an idle pipeline
        idle_cycles(50);

        for (int n = 0; n < 8; n++) begin
            re[n] = 0;
            im[n] = 0;
        end
        re[0] = 12000;
        send_frame("impulse", re, im, 0);
        wait_drain("impulse");

        for (int n = 0; n < 8; n++) begin
            re[n] = -5000;
            im[n] = 3000;
        end
        send_frame("constant", re, im, 0);
        wait_drain("constant");

        // e^(+j*2*pi*n/8) lands in bin 1
        re = '{16384, 11585, 0, -11585, -16384, -11585, 0, 11585};
        im = '{0, 11585, 16384, 11585, 0, -11585, -16384, -11585};
        send_frame("exp_bin1", re, im, 0);
        wait_drain("exp_bin1");

        for (int f = 0; f < 20; f++) begin
            for (int n = 0; n < 8; n++) begin
                re[n] = next_sample();
                im[n] = next_sample();
            end
            send_frame("random_b2b", re, im, 0);
        end
        wait_drain("random_b2b");

        for (int f = 0; f < 15; f++) begin
            for (int n = 0; n < 8; n++) begin
                re[n] = next_sample();
                im[n] = next_sample();
            end
            gap = int'(next_rand() % 32'd7);
            send_frame("random_gaps", re, im, gap);
        end
        wait_drain("random_gaps");
        idle_cycles(20);

        $display("Errors: mismatch %0d, timing %0d, other %0d",
                 mismatch_errs, timing_errs, other_errs);
        if (mismatch_errs + timing_errs + other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fft_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_top (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire fft_pkg::complex_t sample_in,
    input  wire                    sample_valid,
    output fft_pkg::spectrum_t     spectrum,
    output logic                   spectrum_valid
);

    fft_pkg::complex_t pair_lo;
    fft_pkg::complex_t pair_hi;
    logic              pair_valid;

    input_pairing pairing (
        .clk(clk),
        .arst_n(arst_n),
        .sample_in(sample_in),
        .sample_valid(sample_valid),
        .data_0(pair_lo),
        .data_1(pair_hi),
        .pair_valid(pair_valid)
    );

    fft_8_rad2 core (
        .clk(clk),
        .arst_n(arst_n),
        .enable(pair_valid),
        .data_0(pair_lo),
        .data_1(pair_hi),
        .fft_out(spectrum),
        .out_valid(spectrum_valid)
    );

endmodule

`default_nettype wire

// File: verilog/input_pairing.sv
`timescale 1ns/1ps
`default_nettype none

module input_pairing (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire fft_pkg::complex_t sample_in,
    input  wire                    sample_valid,
    output fft_pkg::complex_t      data_0,
    output fft_pkg::complex_t      data_1,
    output logic                   pair_valid
);

    fft_pkg::pair_state_t state;
    fft_pkg::bin_idx_t    pos;
    fft_pkg::pair_idx_t   slot;
    fft_pkg::complex_t    low_buf [fft_pkg::fft_half];

    // Sample n and n+4 share a slot
    assign slot = pos[$bits(slot)-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= fft_pkg::load_low;
            pos        <= '0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= 1'b0;
            if (sample_valid) begin
                pos <= pos + 1'b1;
                case (state)
                    fft_pkg::load_low: begin
                        if (slot == '1) begin
                            state <= fft_pkg::emit_pairs;
                        end
                    end
                    fft_pkg::emit_pairs: begin
                        pair_valid <= 1'b1;
                        // Eighth sample closes the frame
                        if (pos == '1) begin
                            state <= fft_pkg::load_low;
                        end
                    end
                    default: begin
                        state <= fft_pkg::load_low;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            if (state == fft_pkg::load_low) begin
                low_buf[slot] <= sample_in;
            end else begin
                data_0 <= low_buf[slot];
                data_1 <= sample_in;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/input_reorder.sv
`timescale 1ns/1ps
`default_nettype none

module input_reorder (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     enable,
    input  wire fft_pkg::spectrum_t input_array,
    output fft_pkg::spectrum_t      output_array,
    output logic                    out_valid
);

    function automatic fft_pkg::bin_idx_t bitrev(input fft_pkg::bin_idx_t idx);
        fft_pkg::bin_idx_t rev;
        for (int i = 0; i < $bits(idx); i++) begin
            rev[i] = idx[$bits(idx)-1-i];
        end
        return rev;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= enable;
        end
    end

    // Natural bin order on the way out
    always_ff @(posedge clk) begin
        if (enable) begin
            for (int k = 0; k < fft_pkg::fft_n; k++) begin
                output_array[k] <= input_array[bitrev(fft_pkg::bin_idx_t'(k))];
            end
        end
    end

endmodule

`default_nettype wire
